// File: Makefile
VERILATOR  := verilator
TOP        := tb_io_subsystem
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
PASS_MSG   := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/io_pkg.sv
// Peripheral I/O subsystem package with bus widths, address map and register offsets
package io_pkg;

   // ****************************************
   // Bus widths
   // ****************************************
   localparam int WB_DW = 32;
   localparam int WB_AW = 16;

   // Address fields as seen by the decoder and the slaves
   typedef struct packed {
      logic [3:0] sel;      // slave select, bits 15:12
      logic [8:0] reg_off;  // 64-bit register index, bits 11:3
      logic       half;     // upper word of a 64-bit register
      logic [1:0] lane;     // byte lane
   } wb_addr_f_t;

   typedef union packed {
      logic [WB_AW-1:0] raw;
      wb_addr_f_t       f;
   } wb_addr_u;

   // ****************************************
   // Address map
   // ****************************************
   localparam logic [3:0] SEL_SYSCON = 4'h1;
   localparam logic [3:0] SEL_SPI    = 4'h2;

   // System controller byte offsets
   localparam logic [11:0] SYS_GPIO_OUT = 12'h000;
   localparam logic [11:0] SYS_GPIO_IN  = 12'h004;
   localparam logic [11:0] SYS_SW_IRQ   = 12'h008;
   localparam logic [11:0] SYS_MTIME    = 12'h010;
   localparam logic [11:0] SYS_MTIMECMP = 12'h014;

   // SPI register indices, 8 bytes apart
   localparam logic [8:0] SPI_CTRL = 9'd0;
   localparam logic [8:0] SPI_DATA = 9'd1;
   localparam logic [8:0] SPI_STAT = 9'd2;

   localparam int IRQ_W = 3;

endpackage

// File: rtl/io_subsystem.sv
// I/O subsystem top joining the Wishbone decoder, system controller and SPI flash master
`timescale 1ns/1ps

module io_subsystem #(
   parameter int GPIO_W  = 32,
   parameter int SPI_DIV = 2
) (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic [io_pkg::WB_AW-1:0]  i_wb_adr,
   input  logic [io_pkg::WB_DW-1:0]  i_wb_dat,
   input  logic [3:0]                i_wb_sel,
   input  logic                      i_wb_we,
   input  logic                      i_wb_cyc,
   input  logic                      i_wb_stb,
   output logic [io_pkg::WB_DW-1:0]  o_wb_rdt,
   output logic                      o_wb_ack,
   output logic                      o_wb_err,
   input  logic [GPIO_W-1:0]         i_gpio,
   output logic [GPIO_W-1:0]         o_gpio,
   output logic                      o_spi_sclk,
   output logic                      o_spi_cs_n,
   output logic                      o_spi_mosi,
   input  logic                      i_spi_miso,
   output logic [io_pkg::IRQ_W-1:0]  o_irq,
   output logic                      o_timer_irq
);
   import io_pkg::*;

   logic             syscon_stb;
   logic             spi_stb;
   logic [WB_DW-1:0] syscon_rdt;
   logic [WB_DW-1:0] spi_rdt;
   logic             syscon_ack;
   logic             spi_ack;
   logic             spi_irq;
   logic             sw_irq3;
   logic             sw_irq4;

   // External interrupt lines, SPI in bit 0
   assign o_irq = {sw_irq4, sw_irq3, spi_irq};

   wb_decoder wb_decoder_inst (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_wb_adr     (i_wb_adr),
      .i_wb_cyc     (i_wb_cyc),
      .i_wb_stb     (i_wb_stb),
      .o_syscon_stb (syscon_stb),
      .o_spi_stb    (spi_stb),
      .i_syscon_rdt (syscon_rdt),
      .i_spi_rdt    (spi_rdt),
      .i_syscon_ack (syscon_ack),
      .i_spi_ack    (spi_ack),
      .o_wb_rdt     (o_wb_rdt),
      .o_wb_ack     (o_wb_ack),
      .o_wb_err     (o_wb_err)
   );

   syscon #(
      .GPIO_W (GPIO_W)
   ) syscon_inst (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_adr       (i_wb_adr),
      .i_dat       (i_wb_dat),
      .i_sel       (i_wb_sel),
      .i_we        (i_wb_we),
      .i_stb       (syscon_stb),
      .o_rdt       (syscon_rdt),
      .o_ack       (syscon_ack),
      .i_gpio      (i_gpio),
      .o_gpio      (o_gpio),
      .o_sw_irq3   (sw_irq3),
      .o_sw_irq4   (sw_irq4),
      .o_timer_irq (o_timer_irq)
   );

   // SPI master has a byte-wide data path
   spi_ctrl #(
      .SPI_DIV (SPI_DIV)
   ) spi_ctrl_inst (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_adr   (i_wb_adr),
      .i_dat   (i_wb_dat[7:0]),
      .i_we    (i_wb_we),
      .i_stb   (spi_stb),
      .o_rdt   (spi_rdt),
      .o_ack   (spi_ack),
      .o_irq   (spi_irq),
      .o_sclk  (o_spi_sclk),
      .o_cs_n  (o_spi_cs_n),
      .o_mosi  (o_spi_mosi),
      .i_miso  (i_spi_miso)
   );

endmodule

// File: rtl/spi_ctrl.sv
// Byte-wide mode-0 SPI flash master with a Wishbone register window and done interrupt
`timescale 1ns/1ps

module spi_ctrl #(
   parameter int SPI_DIV = 2
) (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  io_pkg::wb_addr_u         i_adr,
   input  logic [7:0]               i_dat,
   input  logic                     i_we,
   input  logic                     i_stb,
   output logic [io_pkg::WB_DW-1:0] o_rdt,
   output logic                     o_ack,
   output logic                     o_irq,
   output logic                     o_sclk,
   output logic                     o_cs_n,
   output logic                     o_mosi,
   input  logic                     i_miso
);
   import io_pkg::*;

   localparam int DIV_W = $clog2(SPI_DIV + 1);

   // Shift engine states
   localparam logic [1:0] ST_IDLE    = 2'd0;
   localparam logic [1:0] ST_SETUP   = 2'd1;
   localparam logic [1:0] ST_SHIFT   = 2'd2;
   localparam logic [1:0] ST_RELEASE = 2'd3;

   logic             ack_q;
   logic             access;
   logic             wr_en;
   logic             rd_en;
   logic [8:0]       rd_reg;
   logic [1:0]       ctrl_q;
   logic             done_q;
   logic             busy;
   logic [1:0]       state_q;
   logic [DIV_W-1:0] div_q;
   logic             div_end;
   logic [2:0]       bit_q;
   logic             sclk_q;
   logic             miso_q;
   logic [7:0]       shift_q;

   assign access = i_stb & ~ack_q;
   // Upper-word writes land on no register
   assign wr_en  = access & i_we & ~i_adr.f.half;
   assign rd_en  = access & ~i_we;

   // Upper-word reads are sent to CTRL so a split 64-bit read pops DATA only once
   assign rd_reg = i_adr.f.half ? SPI_CTRL : i_adr.f.reg_off;

   assign busy    = (state_q != ST_IDLE);
   assign div_end = (div_q == DIV_W'(SPI_DIV - 1));

   // ****************************************
   // Registers and shift engine
   // ****************************************
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q   <= 1'b0;
         ctrl_q  <= 2'b00;
         done_q  <= 1'b0;
         state_q <= ST_IDLE;
         div_q   <= '0;
         bit_q   <= 3'd0;
         sclk_q  <= 1'b0;
         miso_q  <= 1'b0;
         shift_q <= 8'h00;
      end else begin
         ack_q <= i_stb & ~ack_q;

         if (wr_en && i_adr.f.reg_off == SPI_CTRL) begin
            ctrl_q <= i_dat[1:0];
         end

         // Reading the received byte acknowledges it
         if (rd_en && rd_reg == SPI_DATA) begin
            done_q <= 1'b0;
         end

         case (state_q)
            ST_IDLE: begin
               if (wr_en && i_adr.f.reg_off == SPI_DATA && ctrl_q[0]) begin
                  shift_q <= i_dat;
                  done_q  <= 1'b0;
                  state_q <= ST_SETUP;
               end
            end
            ST_SETUP: begin
               // One clock of chip select before the first edge
               div_q   <= '0;
               bit_q   <= 3'd0;
               state_q <= ST_SHIFT;
            end
            ST_SHIFT: begin
               if (div_end) begin
                  div_q  <= '0;
                  sclk_q <= ~sclk_q;
                  if (!sclk_q) begin
                     miso_q <= i_miso;
                  end else begin
                     // Falling edge, next MSB goes out
                     shift_q <= {shift_q[6:0], miso_q};
                     bit_q   <= bit_q + 3'd1;
                     if (bit_q == 3'd7) begin
                        state_q <= ST_RELEASE;
                     end
                  end
               end else begin
                  div_q <= div_q + 1'b1;
               end
            end
            ST_RELEASE: begin
               done_q  <= 1'b1;
               state_q <= ST_IDLE;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // ****************************************
   // Read mux and outputs
   // ****************************************
   always_comb begin
      case (rd_reg)
         SPI_CTRL: o_rdt = WB_DW'(ctrl_q);
         SPI_DATA: o_rdt = WB_DW'(shift_q);
         SPI_STAT: o_rdt = WB_DW'({done_q, busy});
         default:  o_rdt = '0;
      endcase
   end

   assign o_ack  = ack_q;
   assign o_irq  = done_q & ctrl_q[1];
   assign o_sclk = sclk_q;
   assign o_cs_n = ~busy;
   assign o_mosi = shift_q[7];

endmodule

// File: rtl/syscon.sv
// System controller with GPIO registers, software interrupts and a machine timer
`timescale 1ns/1ps

module syscon #(
   parameter int GPIO_W = 32
) (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  io_pkg::wb_addr_u         i_adr,
   input  logic [io_pkg::WB_DW-1:0] i_dat,
   input  logic [3:0]               i_sel,
   input  logic                     i_we,
   input  logic                     i_stb,
   output logic [io_pkg::WB_DW-1:0] o_rdt,
   output logic                     o_ack,
   input  logic [GPIO_W-1:0]        i_gpio,
   output logic [GPIO_W-1:0]        o_gpio,
   output logic                     o_sw_irq3,
   output logic                     o_sw_irq4,
   output logic                     o_timer_irq
);
   import io_pkg::*;

   logic [11:0]       offset;
   logic [WB_DW-1:0]  wmask;
   logic              wr_en;
   logic              ack_q;
   logic [GPIO_W-1:0] gpio_out_q;
   logic [GPIO_W-1:0] gpio_in_q;
   logic [1:0]        sw_irq_q;
   logic [WB_DW-1:0]  mtime_q;
   logic [WB_DW-1:0]  mtimecmp_q;
   logic              timer_irq_q;

   // Keep the old bits outside the selected byte lanes
   function automatic logic [WB_DW-1:0] merge(input logic [WB_DW-1:0] old_val,
                                              input logic [WB_DW-1:0] new_val,
                                              input logic [WB_DW-1:0] mask);
      merge = (old_val & ~mask) | (new_val & mask);
   endfunction

   // Word offset inside the 4 KiB window, lane bits dropped
   assign offset = {i_adr.raw[11:2], 2'b00};
   assign wmask  = {{8{i_sel[3]}}, {8{i_sel[2]}}, {8{i_sel[1]}}, {8{i_sel[0]}}};
   assign wr_en  = i_stb & i_we & ~ack_q;

   // ****************************************
   // Registers and timer
   // ****************************************
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q       <= 1'b0;
         gpio_out_q  <= '0;
         sw_irq_q    <= 2'b00;
         mtime_q     <= '0;
         mtimecmp_q  <= '1;
         timer_irq_q <= 1'b0;
      end else begin
         ack_q       <= i_stb & ~ack_q;
         timer_irq_q <= (mtime_q >= mtimecmp_q);
         mtime_q     <= mtime_q + 1'b1;
         if (wr_en) begin
            case (offset)
               SYS_GPIO_OUT: gpio_out_q <= GPIO_W'(merge(WB_DW'(gpio_out_q), i_dat, wmask));
               SYS_SW_IRQ:   sw_irq_q   <= 2'(merge(WB_DW'(sw_irq_q), i_dat, wmask));
               SYS_MTIME:    mtime_q    <= merge(mtime_q, i_dat, wmask);
               SYS_MTIMECMP: mtimecmp_q <= merge(mtimecmp_q, i_dat, wmask);
               default: ;
            endcase
         end
      end
   end

   // Input sampling for the GPIO_IN view
   always_ff @(posedge clk) begin
      gpio_in_q <= i_gpio;
   end

   // ****************************************
   // Read mux
   // ****************************************
   always_comb begin
      case (offset)
         SYS_GPIO_OUT: o_rdt = WB_DW'(gpio_out_q);
         SYS_GPIO_IN:  o_rdt = WB_DW'(gpio_in_q);
         SYS_SW_IRQ:   o_rdt = WB_DW'(sw_irq_q);
         SYS_MTIME:    o_rdt = mtime_q;
         SYS_MTIMECMP: o_rdt = mtimecmp_q;
         default:      o_rdt = '0;
      endcase
   end

   assign o_ack       = ack_q;
   assign o_gpio      = gpio_out_q;
   assign o_sw_irq3   = sw_irq_q[0];
   assign o_sw_irq4   = sw_irq_q[1];
   assign o_timer_irq = timer_irq_q;

endmodule

// File: rtl/wb_decoder.sv
// Wishbone address decoder that steers strobes, muxes responses and flags unmapped accesses
`timescale 1ns/1ps

module wb_decoder (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  io_pkg::wb_addr_u         i_wb_adr,
   input  logic                     i_wb_cyc,
   input  logic                     i_wb_stb,
   output logic                     o_syscon_stb,
   output logic                     o_spi_stb,
   input  logic [io_pkg::WB_DW-1:0] i_syscon_rdt,
   input  logic [io_pkg::WB_DW-1:0] i_spi_rdt,
   input  logic                     i_syscon_ack,
   input  logic                     i_spi_ack,
   output logic [io_pkg::WB_DW-1:0] o_wb_rdt,
   output logic                     o_wb_ack,
   output logic                     o_wb_err
);
   import io_pkg::*;

   logic req;
   logic hit_syscon;
   logic hit_spi;
   logic err_q;

   assign req        = i_wb_cyc & i_wb_stb;
   assign hit_syscon = (i_wb_adr.f.sel == SEL_SYSCON);
   assign hit_spi    = (i_wb_adr.f.sel == SEL_SPI);

   // Slaves never see cyc, so it is folded into their strobe
   assign o_syscon_stb = req & hit_syscon;
   assign o_spi_stb    = req & hit_spi;

   // ****************************************
   // Unmapped access error
   // ****************************************
   // Self-clearing, so a held request still gives a single pulse
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req & ~hit_syscon & ~hit_spi & ~err_q;
      end
   end

   assign o_wb_err = err_q;

   // ****************************************
   // Response mux
   // ****************************************
   always_comb begin
      case (i_wb_adr.f.sel)
         SEL_SYSCON: begin
            o_wb_rdt = i_syscon_rdt;
            o_wb_ack = i_syscon_ack;
         end
         SEL_SPI: begin
            o_wb_rdt = i_spi_rdt;
            o_wb_ack = i_spi_ack;
         end
         default: begin
            // Error path returns zero data
            o_wb_rdt = '0;
            o_wb_ack = 1'b0;
         end
      endcase
   end

endmodule

// File: sim/io_stimulus.txt
# op addr sel data mask, all hex; W write, R read under mask, U read above last, P poll
# E expect bus error, G o_gpio, I o_irq, T o_timer_irq (data under mask)
W 1000 f 12345678 ffffffff
G 0000 0 12345678 ffffffff
W 1000 4 aabbccdd ffffffff
G 0000 0 12bb5678 ffffffff
R 1000 f 12bb5678 ffffffff
R 1004 f a5c30f96 ffffffff
W 1008 f 00000003 ffffffff
I 0000 0 00000006 00000006
R 1008 f 00000003 ffffffff
W 1008 f 00000001 ffffffff
I 0000 0 00000002 00000006
W 1008 f 00000000 ffffffff
I 0000 0 00000000 00000006
T 0000 0 00000000 00000001
W 1014 f 00000000 ffffffff
T 0000 0 00000001 00000001
R 1010 f 00000000 00000000
U 1010 f 00000000 00000000
W 2000 f 00000003 ffffffff
W 2008 f 0000005a ffffffff
P 2010 f 00000002 00000003
I 0000 0 00000001 00000001
R 2008 f 0000005a ffffffff
I 0000 0 00000000 00000001
W 2008 f 000000c3 ffffffff
P 2010 f 00000002 00000003
R 200c f 00000003 ffffffff
I 0000 0 00000001 00000001
R 2008 f 000000c3 ffffffff
I 0000 0 00000000 00000001
E 3000 f 00000000 00000000

// File: sim/tb_clk_gen.sv
// Testbench clock generator, free running from time zero
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD = 100
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD / 2) o_clk = ~o_clk;
   end

endmodule

// File: sim/tb_io_subsystem.sv
// Testbench for the I/O subsystem, replays Wishbone operations from a stimulus file
`timescale 1ns/1ps

module tb_io_subsystem;

   localparam logic [31:0] GPIO_IN_VAL = 32'ha5c30f96;
   localparam int          SPI_DIV     = 2;
   localparam int          BUS_TIMEOUT = 20;
   localparam int          POLL_MAX    = 100;

   logic        clk;
   logic        rst_n;
   logic [15:0] wb_adr;
   logic [31:0] wb_dat;
   logic [3:0]  wb_sel;
   logic        wb_we;
   logic        wb_cyc;
   logic        wb_stb;
   logic [31:0] wb_rdt;
   logic        wb_ack;
   logic        wb_err;
   logic [31:0] gpio_out;
   logic        spi_sclk;
   logic        spi_cs_n;
   logic        spi_mosi;
   logic [2:0]  irq;
   logic        timer_irq;
   logic [31:0] last_rdt;
   logic        sclk_prev;
   int          sclk_rises;
   int          cs_low_cycles;
   int          frames;
   int          mismatches;
   int          timeouts;
   int          other_errs;

   tb_clk_gen #(.PERIOD(100)) tb_clk_gen_inst (.o_clk(clk));

   // MISO looped back to MOSI
   io_subsystem #(
      .GPIO_W  (32),
      .SPI_DIV (SPI_DIV)
   ) io_subsystem_inst (
      .clk         (clk),
      .i_rst_n     (rst_n),
      .i_wb_adr    (wb_adr),
      .i_wb_dat    (wb_dat),
      .i_wb_sel    (wb_sel),
      .i_wb_we     (wb_we),
      .i_wb_cyc    (wb_cyc),
      .i_wb_stb    (wb_stb),
      .o_wb_rdt    (wb_rdt),
      .o_wb_ack    (wb_ack),
      .o_wb_err    (wb_err),
      .i_gpio      (GPIO_IN_VAL),
      .o_gpio      (gpio_out),
      .o_spi_sclk  (spi_sclk),
      .o_spi_cs_n  (spi_cs_n),
      .o_spi_mosi  (spi_mosi),
      .i_spi_miso  (spi_mosi),
      .o_irq       (irq),
      .o_timer_irq (timer_irq)
   );

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("[FAIL] %0t: %s, expected %h, got %h", $time, what, expected, actual);
         mismatches = mismatches + 1;
      end
   endtask

   // ****************************************
   // SPI pin monitor
   // ****************************************
   // Sclk idles low outside a frame, and each frame carries one byte
   always @(negedge clk) begin
      if (rst_n) begin
         if (spi_cs_n) begin
            check_value({31'b0, spi_sclk}, 32'd0, "o_spi_sclk idle level");
            if (cs_low_cycles != 0) begin
               check_value(sclk_rises, 32'd8, "sclk rising edges per byte");
               check_value(cs_low_cycles, 16 * SPI_DIV + 2, "o_spi_cs_n low time");
               frames = frames + 1;
            end
            cs_low_cycles = 0;
            sclk_rises    = 0;
         end else begin
            if (spi_sclk && !sclk_prev) begin
               sclk_rises = sclk_rises + 1;
            end
            cs_low_cycles = cs_low_cycles + 1;
         end
         sclk_prev = spi_sclk;
      end
   end

   // ****************************************
   // Bus access
   // ****************************************
   task automatic bus_cycle(input logic [15:0] adr, input logic [3:0] sel, input logic we,
                            input logic [31:0] dat, output logic [31:0] rdt,
                            output logic ack, output logic err);
      int waited;
      @(negedge clk);
      wb_adr = adr;
      wb_sel = sel;
      wb_we  = we;
      wb_dat = dat;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      rdt    = '0;
      ack    = 1'b0;
      err    = 1'b0;
      waited = 0;
      while (!ack && !err && waited < BUS_TIMEOUT) begin
         @(negedge clk);
         ack    = wb_ack;
         err    = wb_err;
         rdt    = wb_rdt;
         waited = waited + 1;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      if (!ack && !err) begin
         $display("Timeout: no ack or err from the bus at address %h", adr);
         timeouts = timeouts + 1;
      end
   endtask

   task automatic poll_reg(input logic [15:0] adr, input logic [3:0] sel,
                           input logic [31:0] value, input logic [31:0] mask);
      logic [31:0] rdt;
      logic        ack;
      logic        err;
      logic        hit;
      int          tries;
      hit   = 1'b0;
      tries = 0;
      while (!hit && tries < POLL_MAX) begin
         bus_cycle(adr, sel, 1'b0, 32'h0, rdt, ack, err);
         hit   = ((rdt & mask) == (value & mask));
         tries = tries + 1;
      end
      if (!hit) begin
         $display("Timeout: register at %h never reached %h under mask %h", adr, value, mask);
         timeouts = timeouts + 1;
      end
   endtask

   // One line of the stimulus file
   task automatic run_op(input logic [7:0] op, input logic [15:0] adr, input logic [3:0] sel,
                         input logic [31:0] dat, input logic [31:0] mask);
      logic [31:0] rdt;
      logic        ack;
      logic        err;
      case (op)
         "W": begin
            bus_cycle(adr, sel, 1'b1, dat, rdt, ack, err);
            check_value({30'b0, err, ack}, 32'd1, $sformatf("write ack at %h", adr));
         end
         "R": begin
            bus_cycle(adr, sel, 1'b0, 32'h0, rdt, ack, err);
            check_value({30'b0, err, ack}, 32'd1, $sformatf("read ack at %h", adr));
            check_value(rdt & mask, dat & mask, $sformatf("read at %h", adr));
            last_rdt = rdt;
         end
         "U": begin
            bus_cycle(adr, sel, 1'b0, 32'h0, rdt, ack, err);
            check_value({31'b0, rdt > last_rdt}, 32'd1, $sformatf("rising read at %h", adr));
            last_rdt = rdt;
         end
         "P": poll_reg(adr, sel, dat, mask);
         "E": begin
            bus_cycle(adr, sel, 1'b0, 32'h0, rdt, ack, err);
            check_value({30'b0, err, ack}, 32'd2, $sformatf("error response at %h", adr));
            check_value(rdt, 32'h0, $sformatf("error read data at %h", adr));
         end
         "G": begin
            @(negedge clk);
            check_value(gpio_out & mask, dat & mask, "o_gpio");
         end
         "I": begin
            @(negedge clk);
            check_value({29'b0, irq} & mask, dat & mask, "o_irq");
         end
         "T": begin
            @(negedge clk);
            check_value({31'b0, timer_irq} & mask, dat & mask, "o_timer_irq");
         end
         default: begin
            $display("Unknown operation %c in the stimulus file", op);
            other_errs = other_errs + 1;
         end
      endcase
   endtask

   // ****************************************
   // Main sequence
   // ****************************************
   initial begin
      int          fd;
      int          code;
      string       line;
      logic [7:0]  op;
      logic [31:0] f_adr;
      logic [31:0] f_sel;
      logic [31:0] f_dat;
      logic [31:0] f_mask;
      mismatches    = 0;
      timeouts      = 0;
      other_errs    = 0;
      last_rdt      = '0;
      sclk_prev     = 1'b0;
      sclk_rises    = 0;
      cs_low_cycles = 0;
      frames        = 0;
      rst_n         = 1'b0;
      wb_adr        = '0;
      wb_dat        = '0;
      wb_sel        = '0;
      wb_we         = 1'b0;
      wb_cyc        = 1'b0;
      wb_stb        = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      // Reset state of the outputs
      check_value({31'b0, wb_ack}, 32'd0, "o_wb_ack in reset");
      check_value({31'b0, wb_err}, 32'd0, "o_wb_err in reset");
      check_value({29'b0, irq}, 32'd0, "o_irq in reset");
      check_value({31'b0, timer_irq}, 32'd0, "o_timer_irq in reset");
      check_value({31'b0, spi_cs_n}, 32'd1, "o_spi_cs_n in reset");
      check_value(gpio_out, 32'd0, "o_gpio in reset");
      rst_n = 1'b1;

      fd = $fopen("sim/io_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file sim/io_stimulus.txt");
         other_errs = other_errs + 1;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            op   = "#";
            code = $sscanf(line, "%c %h %h %h %h", op, f_adr, f_sel, f_dat, f_mask);
            // Comments and blank lines fall through
            if (code == 5 && op != "#") begin
               run_op(op, f_adr[15:0], f_sel[3:0], f_dat, f_mask);
            end
         end
         $fclose(fd);
      end

      // Two byte transfers are started by the stimulus
      check_value(frames, 32'd2, "SPI frames seen");

      $display("Summary: %0d mismatches, %0d timeouts, %0d other errors",
               mismatches, timeouts, other_errs);
      if (mismatches + timeouts + other_errs == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: src.f
rtl/io_pkg.sv
rtl/wb_decoder.sv
rtl/syscon.sv
rtl/spi_ctrl.sv
rtl/io_subsystem.sv
sim/tb_clk_gen.sv
sim/tb_io_subsystem.sv
